//--- common/uart_cfg_pkg.sv
// Serial frame constants, baud default and the bit position counter type
package uart_cfg_pkg;

    // Data bits carried by one frame, sent LSB first
    localparam int DATA_BITS = 8;

    // Clocks per serial bit when the top level does not override it
    localparam int CLKS_PER_BIT_DEFAULT = 16;

    // Counts start, data and stop positions of a frame
    typedef logic [3:0] bit_idx_t;

    // Frame positions
    localparam bit_idx_t START_IDX = bit_idx_t'(0);
    localparam bit_idx_t STOP_IDX  = bit_idx_t'(DATA_BITS + 1);

endpackage

//--- common/uart_host_pkg.sv
// Host-side data byte, received entry and status word types
package uart_host_pkg;

    // One data byte as seen by the host
    typedef logic [7:0] byte_t;

    // Received byte with its frame error flag
    typedef struct packed {
        byte_t data;
        logic  frame_err;
    } rx_entry_t;

    // Status word, registered in the host port
    typedef struct packed {
        logic tx_not_full;
        logic tx_empty;
        logic rx_avail;
        // Sticky, cleared by the next completed read
        logic rx_overrun;
    } uart_status_t;

endpackage

//--- hdl/sync_fifo.sv
// Synchronous first-word-fall-through FIFO with a type parameter payload
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T = logic [7:0],
    parameter int FIFO_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic full,
    output logic empty
);

    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    T mem [FIFO_DEPTH];

    // Extra MSB tells a full buffer from an empty one
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Head is visible without a pop
    assign rdata = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wdata;
        end
    end

endmodule

//--- uart_phy/uart_tx.sv
// Serial frame transmitter with baud counter, shift register and busy flag
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_start,
    input  uart_host_pkg::byte_t tx_data,
    output logic                 tx_busy,
    output logic                 tx
);

    import uart_cfg_pkg::*;
    import uart_host_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    bit_idx_t         bit_idx;
    byte_t            shift;
    logic             bit_tick;

    assign bit_tick = (clk_cnt == BIT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= START_IDX;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Start bit goes out right away
                tx_busy <= 1'b1;
                tx      <= 1'b0;
                clk_cnt <= '0;
                bit_idx <= START_IDX;
            end
        end else if (bit_tick) begin
            clk_cnt <= '0;
            if (bit_idx == STOP_IDX) begin
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                // Last data bit done, stop bit next
                tx      <= (bit_idx == bit_idx_t'(DATA_BITS)) ? 1'b1 : shift[0];
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shift <= tx_data;
        end else if (tx_busy && bit_tick && (bit_idx < bit_idx_t'(DATA_BITS))) begin
            shift <= shift >> 1;
        end
    end

endmodule

//--- uart_phy/uart_rx.sv
// Serial frame receiver with synchronizer, mid-bit sampling and frame error check
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx,
    output logic                     rx_valid,
    output uart_host_pkg::rx_entry_t rx_entry
);

    import uart_cfg_pkg::*;
    import uart_host_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(HALF - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             start_edge;
    logic             bit_tick;
    logic [CNT_W-1:0] clk_cnt;
    bit_idx_t         bit_idx;
    byte_t            shift;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;
    assign bit_tick   = (clk_cnt == BIT_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= START_IDX;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        state   <= RX_START;
                        clk_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        bit_idx <= START_IDX;
                        // Glitch, line already back high
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        clk_cnt  <= '0;
                        rx_valid <= 1'b1;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_tick) begin
            shift <= {rx_sync, shift[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && bit_tick) begin
            rx_entry.data      <= shift;
            rx_entry.frame_err <= !rx_sync;
        end
    end

endmodule

//--- hdl/uart_host_port.sv
// Host write and read handshakes, FIFO push and pop control, transmit launch, status
`timescale 1ns/1ps

module uart_host_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_req,
    input  uart_host_pkg::byte_t        wr_data,
    output logic                        wr_ack,
    input  logic                        rd_req,
    output uart_host_pkg::rx_entry_t    rd_data,
    output logic                        rd_ack,
    output uart_host_pkg::uart_status_t status,
    output logic                        tx_push,
    output uart_host_pkg::byte_t        tx_wdata,
    output logic                        tx_pop,
    input  uart_host_pkg::byte_t        tx_head,
    input  logic                        tx_full,
    input  logic                        tx_empty,
    output logic                        rx_push,
    output uart_host_pkg::rx_entry_t    rx_wdata,
    output logic                        rx_pop,
    input  uart_host_pkg::rx_entry_t    rx_head,
    input  logic                        rx_full,
    input  logic                        rx_empty,
    output logic                        tx_start,
    output uart_host_pkg::byte_t        tx_data,
    input  logic                        tx_busy,
    input  logic                        rx_valid,
    input  uart_host_pkg::rx_entry_t    rx_entry
);

    logic rd_done;
    logic overrun_set;

    // Write handshake, wr_ack low is the idle state
    assign tx_push  = wr_req && !wr_ack && !tx_full;
    assign tx_wdata = wr_data;

    // Read handshake, rd_ack low is the idle state
    assign rx_pop  = rd_req && !rd_ack && !rx_empty;
    assign rd_done = rd_ack && !rd_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            if (tx_push) begin
                wr_ack <= 1'b1;
            end else if (wr_ack && !wr_req) begin
                wr_ack <= 1'b0;
            end
            if (rx_pop) begin
                rd_ack <= 1'b1;
            end else if (rd_done) begin
                rd_ack <= 1'b0;
            end
        end
    end

    // Held until the handshake completes
    always_ff @(posedge clk) begin
        if (rx_pop) begin
            rd_data <= rx_head;
        end
    end

    // Launch the next byte as soon as the transmitter is idle
    assign tx_start = !tx_empty && !tx_busy;
    assign tx_pop   = tx_start;
    assign tx_data  = tx_head;

    // Received entry goes to the FIFO, or is lost
    assign rx_push     = rx_valid && !rx_full;
    assign rx_wdata    = rx_entry;
    assign overrun_set = rx_valid && rx_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            status.tx_not_full <= 1'b1;
            status.tx_empty    <= 1'b1;
            status.rx_avail    <= 1'b0;
            status.rx_overrun  <= 1'b0;
        end else begin
            status.tx_not_full <= !tx_full;
            status.tx_empty    <= tx_empty;
            status.rx_avail    <= !rx_empty;
            if (overrun_set) begin
                status.rx_overrun <= 1'b1;
            end else if (rd_done) begin
                status.rx_overrun <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/uart_controller_top.sv
// UART controller top with host port, transmit and receive FIFOs, serial engines
`timescale 1ns/1ps

module uart_controller_top #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::CLKS_PER_BIT_DEFAULT,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_req,
    input  uart_host_pkg::byte_t        wr_data,
    output logic                        wr_ack,
    input  logic                        rd_req,
    output uart_host_pkg::rx_entry_t    rd_data,
    output logic                        rd_ack,
    output uart_host_pkg::uart_status_t status,
    input  logic                        rx,
    output logic                        tx
);

    import uart_host_pkg::*;

    // Transmit side
    logic      tx_push;
    logic      tx_pop;
    logic      tx_full;
    logic      tx_empty;
    byte_t     tx_wdata;
    byte_t     tx_head;
    logic      tx_start;
    byte_t     tx_data;
    logic      tx_busy;

    // Receive side
    logic      rx_push;
    logic      rx_pop;
    logic      rx_full;
    logic      rx_empty;
    rx_entry_t rx_wdata;
    rx_entry_t rx_head;
    logic      rx_valid;
    rx_entry_t rx_entry;

    uart_host_port i_host_port (
        .clk      (clk),
        .rst      (rst),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .wr_ack   (wr_ack),
        .rd_req   (rd_req),
        .rd_data  (rd_data),
        .rd_ack   (rd_ack),
        .status   (status),
        .tx_push  (tx_push),
        .tx_wdata (tx_wdata),
        .tx_pop   (tx_pop),
        .tx_head  (tx_head),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_push  (rx_push),
        .rx_wdata (rx_wdata),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_full  (rx_full),
        .rx_empty (rx_empty),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .rx_valid (rx_valid),
        .rx_entry (rx_entry)
    );

    sync_fifo #(
        .T          (byte_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_pop),
        .rdata (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    sync_fifo #(
        .T          (rx_entry_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .wdata (rx_wdata),
        .pop   (rx_pop),
        .rdata (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_entry (rx_entry)
    );

endmodule

//--- bench/uart_controller_chk.sv
// Concurrent assertions on host handshakes, FIFO control and transmit launch
`timescale 1ns/1ps

module uart_controller_chk (
    input logic clk,
    input logic rst,
    input logic wr_req,
    input logic wr_ack,
    input logic rd_req,
    input logic rd_ack,
    input logic tx_push,
    input logic tx_pop,
    input logic tx_full,
    input logic tx_empty,
    input logic rx_push,
    input logic rx_pop,
    input logic rx_full,
    input logic rx_empty,
    input logic tx_start,
    input logic tx_busy
);

    // Acks rise only while the request is still up
    assert property (@(posedge clk) disable iff (rst) $rose(wr_ack) |-> wr_req)
        else $error("wr_ack rose without wr_req");
    assert property (@(posedge clk) disable iff (rst) $rose(rd_ack) |-> rd_req)
        else $error("rd_ack rose without rd_req");

    // Acks fall only once the request was seen low
    assert property (@(posedge clk) disable iff (rst) $fell(wr_ack) |-> !$past(wr_req))
        else $error("wr_ack fell while wr_req was high");
    assert property (@(posedge clk) disable iff (rst) $fell(rd_ack) |-> !$past(rd_req))
        else $error("rd_ack fell while rd_req was high");

    assert property (@(posedge clk) disable iff (rst) tx_push |-> !tx_full)
        else $error("push into full transmit FIFO");
    assert property (@(posedge clk) disable iff (rst) rx_push |-> !rx_full)
        else $error("push into full receive FIFO");
    assert property (@(posedge clk) disable iff (rst) tx_pop |-> !tx_empty)
        else $error("pop from empty transmit FIFO");
    assert property (@(posedge clk) disable iff (rst) rx_pop |-> !rx_empty)
        else $error("pop from empty receive FIFO");

    assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy)
        else $error("tx_start while transmitter busy");

endmodule

bind uart_host_port uart_controller_chk i_chk (
    .clk      (clk),
    .rst      (rst),
    .wr_req   (wr_req),
    .wr_ack   (wr_ack),
    .rd_req   (rd_req),
    .rd_ack   (rd_ack),
    .tx_push  (tx_push),
    .tx_pop   (tx_pop),
    .tx_full  (tx_full),
    .tx_empty (tx_empty),
    .rx_push  (rx_push),
    .rx_pop   (rx_pop),
    .rx_full  (rx_full),
    .rx_empty (rx_empty),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
);

//--- bench/uart_controller_tb.sv
// Testbench for the UART controller with stimulus tables, serial driver, tx monitor, checks
`timescale 1ns/1ps

module uart_controller_tb;

    import uart_host_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int FIFO_DEPTH    = 4;
    localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
    localparam int ACK_TIMEOUT   = 4 * FRAME_CLKS;
    localparam int STAT_TIMEOUT  = 4 * FRAME_CLKS;
    localparam int SEED          = 32'hded0_14ba;

    localparam uart_status_t STATUS_IDLE =
        '{tx_not_full: 1'b1, tx_empty: 1'b1, rx_avail: 1'b0, rx_overrun: 1'b0};
    localparam uart_status_t STATUS_TX_FULL =
        '{tx_not_full: 1'b0, tx_empty: 1'b0, rx_avail: 1'b0, rx_overrun: 1'b0};
    localparam uart_status_t STATUS_RX_AVAIL =
        '{tx_not_full: 1'b1, tx_empty: 1'b1, rx_avail: 1'b1, rx_overrun: 1'b0};
    localparam uart_status_t STATUS_OVERRUN =
        '{tx_not_full: 1'b1, tx_empty: 1'b1, rx_avail: 1'b1, rx_overrun: 1'b1};
    localparam uart_status_t MASK_RX_AVAIL =
        '{tx_not_full: 1'b0, tx_empty: 1'b0, rx_avail: 1'b1, rx_overrun: 1'b0};
    localparam uart_status_t MASK_OVERRUN =
        '{tx_not_full: 1'b0, tx_empty: 1'b0, rx_avail: 1'b0, rx_overrun: 1'b1};

    typedef struct packed {
        byte_t     data;
        logic      stop_bit;
        rx_entry_t exp;
    } rx_case_t;

    byte_t tx_table [5] = '{8'h55, 8'ha3, 8'h00, 8'hff, 8'h81};

    // A low stop bit must come back as a frame error
    rx_case_t rx_table [4] = '{
        '{data: 8'h3c, stop_bit: 1'b1, exp: '{data: 8'h3c, frame_err: 1'b0}},
        '{data: 8'he7, stop_bit: 1'b0, exp: '{data: 8'he7, frame_err: 1'b1}},
        '{data: 8'h01, stop_bit: 1'b1, exp: '{data: 8'h01, frame_err: 1'b0}},
        '{data: 8'h80, stop_bit: 1'b0, exp: '{data: 8'h80, frame_err: 1'b1}}
    };

    logic         clk = 1'b0;
    logic         rst;
    logic         wr_req;
    byte_t        wr_data;
    logic         wr_ack;
    logic         rd_req;
    rx_entry_t    rd_data;
    logic         rd_ack;
    uart_status_t status;
    logic         rx;
    logic         tx;

    byte_t tx_seen [$];
    int    err_cnt = 0;
    int    test_no = 0;
    int    tests_failed = 0;

    always #5 clk = ~clk;

    uart_controller_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .wr_req  (wr_req),
        .wr_data (wr_data),
        .wr_ack  (wr_ack),
        .rd_req  (rd_req),
        .rd_data (rd_data),
        .rd_ack  (rd_ack),
        .status  (status),
        .rx      (rx),
        .tx      (tx)
    );

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_entry(input string what, input rx_entry_t got, input rx_entry_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h/%b, expected %h/%b", $time, what,
                     got.data, got.frame_err, exp.data, exp.frame_err);
            err_cnt++;
        end
    endtask

    task automatic check_status(input string what, input uart_status_t got,
                                input uart_status_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_no++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_no, name, err_cnt - errs_before);
        end
    endtask

    // Four-phase write, returns how many cycles wr_ack took
    task automatic write_byte(input byte_t b, output int waited);
        int cnt;
        @(posedge clk);
        wr_req  <= 1'b1;
        wr_data <= b;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!wr_ack && cnt < ACK_TIMEOUT);
        if (!wr_ack) abort_run("wr_ack never came for a transmit byte");
        waited = cnt;
        @(posedge clk);
        wr_req <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (wr_ack && cnt < ACK_TIMEOUT);
        if (wr_ack) abort_run("wr_ack stayed high after wr_req dropped");
    endtask

    task automatic read_entry(output rx_entry_t e);
        int cnt;
        @(posedge clk);
        rd_req <= 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!rd_ack && cnt < ACK_TIMEOUT);
        if (!rd_ack) abort_run("rd_ack never came for a read");
        e = rd_data;
        @(posedge clk);
        rd_req <= 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (rd_ack && cnt < ACK_TIMEOUT);
        if (rd_ack) abort_run("rd_ack stayed high after rd_req dropped");
    endtask

    // Start bit, data LSB first, given stop bit, then one idle bit
    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic wait_status(input uart_status_t mask, input uart_status_t val,
                               input string what);
        int cnt;
        cnt = 0;
        while ((status & mask) !== val && cnt < STAT_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if ((status & mask) !== val) abort_run({"status never showed ", what});
    endtask

    task automatic wait_tx_frames(input int n);
        int cnt;
        cnt = 0;
        while (tx_seen.size() < n && cnt < (n + 2) * FRAME_CLKS) begin
            @(negedge clk);
            cnt++;
        end
        if (tx_seen.size() < n) abort_run("transmit frames did not show up on tx");
    endtask

    // Decodes tx at the middle of each bit
    always begin : tx_monitor
        byte_t b;
        @(negedge clk);
        if (rst === 1'b0 && tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            check_bit("tx start bit", tx, 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                b[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit("tx stop bit", tx, 1'b1);
            tx_seen.push_back(b);
        end
    end

    initial begin
        rx_entry_t got_e;
        int        errs_before;
        int        waited;
        int        max_wait;
        void'($urandom(SEED));
        rst     = 1'b1;
        wr_req  = 1'b0;
        wr_data = '0;
        rd_req  = 1'b0;
        rx      = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        errs_before = err_cnt;
        @(negedge clk);
        check_bit("tx after reset", tx, 1'b1);
        check_bit("wr_ack after reset", wr_ack, 1'b0);
        check_bit("rd_ack after reset", rd_ack, 1'b0);
        check_status("status after reset", status, STATUS_IDLE);
        report_test("reset state", errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < 5; i++) begin
            write_byte(tx_table[i], waited);
            repeat ($urandom % 4) @(posedge clk);
        end
        wait_tx_frames(5);
        for (int i = 0; i < 5; i++) begin
            check_byte("tx frame", tx_seen.pop_front(), tx_table[i]);
        end
        report_test("transmit table", errs_before);

        // More bytes than the FIFO holds, so the last writes must stall
        errs_before = err_cnt;
        max_wait = 0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            write_byte(byte_t'(8'hc0 + i), waited);
            if (waited > max_wait) max_wait = waited;
        end
        check_bit("wr_ack held back", max_wait > CLKS_PER_BIT, 1'b1);
        // One byte on the line, the rest fill the FIFO
        check_status("status with full FIFO", status, STATUS_TX_FULL);
        wait_tx_frames(FIFO_DEPTH + 2);
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            check_byte("back-pressure frame", tx_seen.pop_front(), byte_t'(8'hc0 + i));
        end
        check_status("status after last frame", status, STATUS_IDLE);
        report_test("transmit back-pressure", errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < 4; i++) begin
            send_frame(rx_table[i].data, rx_table[i].stop_bit);
            wait_status(MASK_RX_AVAIL, MASK_RX_AVAIL, "rx_avail");
            repeat ($urandom % 4) @(posedge clk);
            read_entry(got_e);
            check_entry("received entry", got_e, rx_table[i].exp);
            check_status("status after read", status, STATUS_IDLE);
        end
        report_test("receive table", errs_before);

        errs_before = err_cnt;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            send_frame(byte_t'(8'h40 + i), 1'b1);
        end
        wait_status(MASK_OVERRUN, MASK_OVERRUN, "rx_overrun");
        check_status("status on overrun", status, STATUS_OVERRUN);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            read_entry(got_e);
            check_entry("entry after overrun", got_e,
                        '{data: byte_t'(8'h40 + i), frame_err: 1'b0});
            if (i == 0) check_status("status after first read", status, STATUS_RX_AVAIL);
        end
        check_status("status after draining", status, STATUS_IDLE);
        report_test("receive overrun", errs_before);

        $display("tests %0d, failed %0d, errors %0d", test_no, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
common/uart_cfg_pkg.sv
common/uart_host_pkg.sv
hdl/sync_fifo.sv
uart_phy/uart_tx.sv
uart_phy/uart_rx.sv
hdl/uart_host_port.sv
hdl/uart_controller_top.sv
bench/uart_controller_chk.sv
bench/uart_controller_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= uart_controller_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
